/* hdl/highway_pkg.sv */
// Note highway shared definitions
`default_nettype none

package highway_pkg;

	// Highway shape
	localparam int NUM_LANES = 5;
	localparam int NUM_ROWS = 8;
	localparam int BLOCK_SIZE = 4; // Block edge in pixels

	// 320x240 screen with 3 bits per colour channel
	localparam int X_WIDTH = 9;
	localparam int Y_WIDTH = 8;
	localparam int COLOUR_WIDTH = 9;

	// Eighth note at 50 MHz
	localparam int BEAT_CYCLES_DEFAULT = 13157895;

	// Vertical geometry
	localparam int ROW_PITCH = 26; // Pixels between rows
	localparam int TOP_MARGIN = 40; // y of row 0

	// Lanes fan out towards the bottom of the screen
	localparam int LANE_BASE_X [NUM_LANES] = '{130, 145, 160, 175, 190};
	localparam int LANE_SLOPE [NUM_LANES] = '{-12, -6, 0, 6, 12}; // x step per row

	// Fret colours as RRRGGGBBB
	localparam logic [COLOUR_WIDTH-1:0] LANE_COLOUR [NUM_LANES] = '{
		9'b000111000, // Green
		9'b111000000, // Red
		9'b111111000, // Yellow
		9'b000000111, // Blue
		9'b111100000 // Orange
	};
	localparam logic [COLOUR_WIDTH-1:0] ERASE_COLOUR = 9'b000000000; // Black

	// One note per lane, bit 0 is lane 0
	typedef logic [NUM_LANES-1:0] lane_row_t;

	typedef logic [2:0] row_idx_t;
	typedef logic [2:0] lane_idx_t;

	// Top left corner of a block and its fill colour
	typedef struct packed {
		logic [X_WIDTH-1:0] x;
		logic [Y_WIDTH-1:0] y;
		logic [COLOUR_WIDTH-1:0] colour;
	} block_req_t;

	// Single pixel write
	typedef struct packed {
		logic [X_WIDTH-1:0] x;
		logic [Y_WIDTH-1:0] y;
		logic [COLOUR_WIDTH-1:0] colour;
	} pixel_t;

endpackage

`default_nettype wire

/* hdl/stream_stage.sv */
// Valid/ready register slice
`timescale 1ns/1ns
`default_nettype none

module stream_stage #(
	parameter type payload_t = logic
) (
	input  logic clk,
	input  logic reset,
	input  payload_t in_data,
	input  logic in_valid,
	output logic in_ready,
	output payload_t out_data,
	output logic out_valid,
	input  logic out_ready
);

	// Free slot, or the held item leaves this cycle
	assign in_ready = !out_valid || out_ready;

	always_ff @(posedge clk)
	begin
		if (reset)
			out_valid <= 1'b0;
		else if (in_ready)
			out_valid <= in_valid; // Refill or go empty
	end

	// Payload only moves on a transfer
	always_ff @(posedge clk)
	begin
		if (in_valid && in_ready)
			out_data <= in_data;
	end

endmodule

`default_nettype wire

/* hdl/beat_timer.sv */
// Beat pulse generator
`timescale 1ns/1ns
`default_nettype none

module beat_timer import highway_pkg::*; #(
	parameter int BEAT_CYCLES = BEAT_CYCLES_DEFAULT
) (
	input  logic clk,
	input  logic reset,
	output logic beat
);

	logic [$clog2(BEAT_CYCLES)-1:0] count; // Cycles into current beat

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			count <= '0;
			beat <= 1'b0;
		end
		else if (int'(count) == BEAT_CYCLES - 1)
		begin
			count <= '0; // Wrap
			beat <= 1'b1; // One cycle pulse
		end
		else
		begin
			count <= count + 1'b1;
			beat <= 1'b0;
		end
	end

endmodule

`default_nettype wire

/* hdl/note_lanes.sv */
// Lane shift registers
`timescale 1ns/1ns
`default_nettype none

module note_lanes import highway_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic shift_en,
	input  lane_row_t new_row,
	input  logic new_row_valid,
	input  row_idx_t scan_row,
	output logic new_row_ready,
	output lane_row_t notes_to_play,
	output lane_row_t row_notes
);

	logic [NUM_ROWS-1:0] lane_sr [NUM_LANES]; // Bit 0 is the top row
	lane_row_t entry_row; // Row pushed in at the top

	// Rows are only taken during the shift cycle
	assign new_row_ready = shift_en;

	// No row offered means an empty row enters
	assign entry_row = new_row_valid ? new_row : '0;

	for (genvar l = 0; l < NUM_LANES; l++)
	begin : g_lane
		always_ff @(posedge clk)
		begin
			if (reset)
				lane_sr[l] <= '0; // Highway starts empty
			else if (shift_en)
				lane_sr[l] <= {lane_sr[l][NUM_ROWS-2:0], entry_row[l]}; // Drop one row
		end

		// Bottom row leaves the highway
		assign notes_to_play[l] = lane_sr[l][NUM_ROWS-1];

		// Read port for the scanner
		assign row_notes[l] = lane_sr[l][scan_row];
	end

endmodule

`default_nettype wire

/* hdl/note_scanner.sv */
// Highway scanner and block request source
`timescale 1ns/1ns
`default_nettype none

module note_scanner import highway_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic scan_start,
	input  logic scan_erase,
	input  lane_row_t row_notes,
	input  logic req_ready,
	input  logic plot_idle,
	output row_idx_t scan_row,
	output block_req_t req,
	output logic req_valid,
	output logic scan_done
);

	typedef enum logic [1:0] {
		SCAN_IDLE,
		SCAN_RUN, // Walking rows and lanes
		SCAN_FLUSH // Waiting for the plotter to drain
	} scan_state_t;

	scan_state_t state;
	lane_idx_t lane;
	logic erase_pass; // Latched at scan start
	logic req_free; // Request register can take a new block
	logic issue; // Current lane holds a note and goes out now
	logic [X_WIDTH-1:0] block_x;
	logic [Y_WIDTH-1:0] block_y;
	logic [COLOUR_WIDTH-1:0] block_colour;

	assign req_free = !req_valid || req_ready;
	assign issue = (state == SCAN_RUN) && req_free && row_notes[lane];

	// Block corner from the lane tables
	always_comb
	begin
		block_x = X_WIDTH'(LANE_BASE_X[lane] + LANE_SLOPE[lane] * int'(scan_row));
		block_y = Y_WIDTH'(ROW_PITCH * int'(scan_row) + TOP_MARGIN);
		block_colour = erase_pass ? ERASE_COLOUR : LANE_COLOUR[lane];
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= SCAN_IDLE;
			scan_row <= '0;
			lane <= '0;
			erase_pass <= 1'b0;
			req_valid <= 1'b0;
			scan_done <= 1'b0;
		end
		else
		begin
			scan_done <= 1'b0;
			if (req_valid && req_ready)
				req_valid <= 1'b0; // Taken by the request stage
			if (issue)
				req_valid <= 1'b1;

			case (state)
				SCAN_IDLE:
				begin
					if (scan_start)
					begin
						state <= SCAN_RUN;
						scan_row <= '0;
						lane <= '0;
						erase_pass <= scan_erase;
					end
				end

				SCAN_RUN:
				begin
					// One lane per cycle, empty lanes just step past
					if (req_free)
					begin
						if (lane == lane_idx_t'(NUM_LANES - 1))
						begin
							lane <= '0;
							if (scan_row == row_idx_t'(NUM_ROWS - 1))
								state <= SCAN_FLUSH; // Last lane of last row
							else
								scan_row <= scan_row + 1'b1;
						end
						else
							lane <= lane + 1'b1;
					end
				end

				SCAN_FLUSH:
				begin
					// Last request gone and plotter empty
					if (!req_valid && plot_idle)
					begin
						scan_done <= 1'b1;
						state <= SCAN_IDLE;
					end
				end

				default: state <= SCAN_IDLE;
			endcase
		end
	end

	// Request payload
	always_ff @(posedge clk)
	begin
		if (issue)
		begin
			req.x <= block_x;
			req.y <= block_y;
			req.colour <= block_colour;
		end
	end

endmodule

`default_nettype wire

/* hdl/block_plotter.sv */
// Block to pixel expander
`timescale 1ns/1ns
`default_nettype none

module block_plotter import highway_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  block_req_t req,
	input  logic req_valid,
	input  logic pixel_ready,
	output logic req_ready,
	output pixel_t pixel,
	output logic pixel_valid,
	output logic plot_idle
);

	block_req_t cur; // Block being drawn
	logic busy; // Pixels of cur still to go
	logic [3:0] pix_cnt; // Offset within the block
	logic last_pix;

	assign last_pix = int'(pix_cnt) == BLOCK_SIZE * BLOCK_SIZE - 1;

	// New block only once the previous one is finished
	assign req_ready = !busy;

	// Nothing held here and nothing offered
	assign plot_idle = !busy && !req_valid;

	// Column steps every BLOCK_SIZE pixels, row steps every pixel
	always_comb
	begin
		pixel_valid = busy;
		pixel.x = cur.x + X_WIDTH'(pix_cnt / BLOCK_SIZE);
		pixel.y = cur.y + Y_WIDTH'(pix_cnt % BLOCK_SIZE);
		pixel.colour = cur.colour;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			pix_cnt <= '0;
		end
		else if (!busy)
		begin
			if (req_valid)
			begin
				busy <= 1'b1; // Start a block
				pix_cnt <= '0;
			end
		end
		else if (pixel_ready)
		begin
			pix_cnt <= pix_cnt + 1'b1; // Advance on accepted pixel only
			if (last_pix)
				busy <= 1'b0; // Sixteenth pixel out
		end
	end

	// Capture the block on the request handshake
	always_ff @(posedge clk)
	begin
		if (!busy && req_valid)
			cur <= req;
	end

endmodule

`default_nettype wire

/* hdl/note_highway.sv */
// Note highway renderer top
`timescale 1ns/1ns
`default_nettype none

module note_highway import highway_pkg::*; #(
	parameter int BEAT_CYCLES = BEAT_CYCLES_DEFAULT
) (
	input  logic clk,
	input  logic reset,
	input  logic start,
	input  lane_row_t new_row,
	input  logic new_row_valid,
	output logic new_row_ready,
	output lane_row_t notes_to_play,
	output pixel_t pixel,
	output logic pixel_valid,
	input  logic pixel_ready
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_SHIFT, // Lanes drop one row
		ST_DRAW,
		ST_WAIT, // Hold the frame until the beat
		ST_ERASE
	} frame_state_t;

	frame_state_t state, state_next;

	logic beat;
	logic shift_en;
	logic scan_start; // First cycle of DRAW or ERASE
	logic scan_erase;
	logic scan_done;
	row_idx_t scan_row;
	lane_row_t row_notes;
	block_req_t req, plot_req;
	logic req_valid, req_ready;
	logic plot_req_valid, plot_req_ready;
	pixel_t plot_pixel;
	logic plot_pixel_valid, plot_pixel_ready;
	logic plot_idle;

	always_comb
	begin
		state_next = state;
		case (state)
			ST_IDLE: if (start) state_next = ST_SHIFT;
			ST_SHIFT: state_next = ST_DRAW; // Single cycle
			ST_DRAW: if (scan_done) state_next = ST_WAIT;
			ST_WAIT: if (beat) state_next = ST_ERASE;
			ST_ERASE: if (scan_done) state_next = ST_SHIFT;
			default: state_next = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= ST_IDLE;
			scan_start <= 1'b0;
		end
		else
		begin
			state <= state_next;
			scan_start <= state_next != state &&
				(state_next == ST_DRAW || state_next == ST_ERASE);
		end
	end

	assign shift_en = state == ST_SHIFT;
	assign scan_erase = state == ST_ERASE;

	beat_timer #(.BEAT_CYCLES(BEAT_CYCLES)) u_beat_timer (
		.clk, .reset, .beat
	);

	note_lanes u_note_lanes (
		.clk, .reset, .shift_en, .new_row, .new_row_valid, .scan_row,
		.new_row_ready, .notes_to_play, .row_notes
	);

	note_scanner u_note_scanner (
		.clk, .reset, .scan_start, .scan_erase, .row_notes, .req_ready, .plot_idle,
		.scan_row, .req, .req_valid, .scan_done
	);

	// Scanner to plotter
	stream_stage #(.payload_t(block_req_t)) u_req_stage (
		.clk, .reset,
		.in_data(req), .in_valid(req_valid), .in_ready(req_ready),
		.out_data(plot_req), .out_valid(plot_req_valid), .out_ready(plot_req_ready)
	);

	block_plotter u_block_plotter (
		.clk, .reset,
		.req(plot_req), .req_valid(plot_req_valid), .pixel_ready(plot_pixel_ready),
		.req_ready(plot_req_ready), .pixel(plot_pixel), .pixel_valid(plot_pixel_valid),
		.plot_idle
	);

	// Plotter to pixel port
	stream_stage #(.payload_t(pixel_t)) u_pixel_stage (
		.clk, .reset,
		.in_data(plot_pixel), .in_valid(plot_pixel_valid), .in_ready(plot_pixel_ready),
		.out_data(pixel), .out_valid(pixel_valid), .out_ready(pixel_ready)
	);

endmodule

`default_nettype wire

/* testbench/note_highway_assertions.sv */
// Note highway port assertions
`timescale 1ns/1ns
`default_nettype none

module note_highway_assertions import highway_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic new_row_ready,
	input  pixel_t pixel,
	input  logic pixel_valid,
	input  logic pixel_ready
);

	int failures = 0; // Failed assertion count
	logic reset_held; // Reset seen at the previous edge

	always_ff @(posedge clk)
		reset_held <= reset;

	// Stalled write holds still until taken
	stall_hold: assert property (@(posedge clk) disable iff (reset)
		pixel_valid && !pixel_ready |=> pixel_valid && $stable(pixel))
	else
	begin
		failures++;
		$error("Pixel write changed while stalled");
	end

	// Ports quiet once reset has taken effect
	reset_quiet: assert property (@(posedge clk)
		reset && reset_held |-> !pixel_valid && !new_row_ready)
	else
	begin
		failures++;
		$error("Valid or ready high during reset");
	end

	ready_pulse: assert property (@(posedge clk) disable iff (reset)
		new_row_ready |=> !new_row_ready) // Single SHIFT cycle
	else
	begin
		failures++;
		$error("New row ready longer than one cycle");
	end

endmodule

bind note_highway note_highway_assertions u_assertions (.*);

`default_nettype wire

/* testbench/tb_note_highway.sv */
// Note highway testbench
`timescale 1ns/1ns
`default_nettype none

module tb_note_highway import highway_pkg::*; ();

	localparam int TB_BEAT_CYCLES = 2000; // Short beat for simulation
	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 10;
	localparam int IDLE_CYCLES = 100; // Start held low
	localparam int NUM_FRAMES = 12;
	// Every note set and a pixel taken about one cycle in four
	localparam int WORST_SCAN = NUM_LANES * NUM_ROWS * (BLOCK_SIZE * BLOCK_SIZE + 2) * 4;
	localparam int TIMEOUT_NS = (RESET_CYCLES + IDLE_CYCLES +
		(NUM_FRAMES + 2) * (TB_BEAT_CYCLES + 2 * WORST_SCAN)) * CLK_PERIOD;

	logic clk;
	logic reset;
	logic start;
	lane_row_t new_row;
	logic new_row_valid;
	logic new_row_ready;
	lane_row_t notes_to_play;
	pixel_t pixel;
	logic pixel_valid;
	logic pixel_ready;

	integer seed;
	lane_row_t model_rows [NUM_ROWS]; // Model highway, row 0 at the top
	pixel_t expected [$]; // Writes still to come, in order
	int shift_count;
	int pixel_count;
	int pixel_errors;
	int notes_errors;
	int stream_errors;
	logic row_taken; // Offered row went in at the last shift
	logic monitor_on;

	note_highway #(.BEAT_CYCLES(TB_BEAT_CYCLES)) DUT (
		.clk, .reset, .start, .new_row, .new_row_valid, .new_row_ready,
		.notes_to_play, .pixel, .pixel_valid, .pixel_ready
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_pixel(input string name, input pixel_t exp, input pixel_t act);
		if (act !== exp)
		begin
			pixel_errors++;
			$display("CHECK FAILED %s: expected %0d,%0d colour %03h, actual %0d,%0d colour %03h",
				name, exp.x, exp.y, exp.colour, act.x, act.y, act.colour);
		end
	endtask

	task automatic check_notes(input string name, input lane_row_t exp, input lane_row_t act);
		if (act !== exp)
		begin
			notes_errors++;
			$display("CHECK FAILED %s: expected %05b, actual %05b", name, exp, act);
		end
	endtask

	// Blocks of one scan, rows top down, lanes left to right
	task automatic queue_pass(input logic erase);
		int bx;
		int by;
		pixel_t p;
		for (int r = 0; r < NUM_ROWS; r++)
			for (int l = 0; l < NUM_LANES; l++)
				if (model_rows[r][l])
				begin
					bx = LANE_BASE_X[l] + LANE_SLOPE[l] * r; // Lanes fan out
					by = ROW_PITCH * r + TOP_MARGIN;
					for (int k = 0; k < BLOCK_SIZE * BLOCK_SIZE; k++)
					begin
						p.x = X_WIDTH'(bx + k / BLOCK_SIZE); // Column every 4 pixels
						p.y = Y_WIDTH'(by + k % BLOCK_SIZE);
						p.colour = erase ? ERASE_COLOUR : LANE_COLOUR[l];
						expected.push_back(p);
					end
				end
	endtask

	task automatic shift_model(input lane_row_t row_in);
		for (int r = NUM_ROWS - 1; r > 0; r--)
			model_rows[r] = model_rows[r - 1];
		model_rows[0] = row_in; // Zeros when nothing offered
	endtask

	// One clock of random stimulus
	task automatic drive_cycle();
		@(posedge clk);
		#1;
		pixel_ready = ($unsigned($random(seed)) % 10) < 7; // About 70 % ready
		if (row_taken || !new_row_valid)
		begin
			// New offer, or a gap, once the old row is gone
			new_row_valid = ($unsigned($random(seed)) % 4) != 0;
			new_row = lane_row_t'($random(seed));
			row_taken = 1'b0;
		end
	endtask

	// Falling edge shows what the next rising edge transfers
	always @(negedge clk)
	begin
		if (monitor_on)
		begin
			check_notes($sformatf("notes after shift %0d", shift_count),
				model_rows[NUM_ROWS - 1], notes_to_play);
			if (pixel_valid && pixel_ready)
			begin
				if (expected.size() == 0)
				begin
					stream_errors++;
					$display("Unexpected pixel write at x=%0d y=%0d after shift %0d",
						pixel.x, pixel.y, shift_count);
				end
				else
					check_pixel($sformatf("pixel %0d", pixel_count),
						expected.pop_front(), pixel);
				pixel_count++;
			end
			if (new_row_ready)
			begin
				if (!start)
				begin
					stream_errors++;
					$display("Highway shifted before start was raised");
				end
				shift_model(new_row_valid ? new_row : '0);
				row_taken = new_row_valid;
				shift_count++;
				queue_pass(1'b0); // Draw
				queue_pass(1'b1); // Erase of the same frame
			end
		end
	end

	initial
	begin
		int total;
		seed = 32'h76988eda;
		reset = 1'b1;
		start = 1'b0;
		new_row = '0;
		new_row_valid = 1'b0;
		pixel_ready = 1'b0;
		row_taken = 1'b0;
		monitor_on = 1'b0;
		shift_count = 0;
		pixel_count = 0;
		pixel_errors = 0;
		notes_errors = 0;
		stream_errors = 0;
		for (int r = 0; r < NUM_ROWS; r++)
			model_rows[r] = '0;

		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		reset = 1'b0;
		monitor_on = 1'b1;

		// Idle highway, no writes and no shifts expected
		repeat (IDLE_CYCLES) drive_cycle();

		start = 1'b1;
		while (shift_count < NUM_FRAMES || expected.size() != 0)
			drive_cycle();
		repeat (20) drive_cycle();

		if (pixel_count == 0)
		begin
			stream_errors++;
			$display("No pixel writes were seen during the frames");
		end

		total = pixel_errors + notes_errors + stream_errors + DUT.u_assertions.failures;
		$display("Errors: pixel %0d, notes %0d, stream %0d, assertion %0d",
			pixel_errors, notes_errors, stream_errors, DUT.u_assertions.failures);
		if (total == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(TIMEOUT_NS);
		$display("Timeout: frames did not complete within %0d ns", TIMEOUT_NS);
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* note_highway.f */
hdl/highway_pkg.sv
hdl/stream_stage.sv
hdl/beat_timer.sv
hdl/note_lanes.sv
hdl/note_scanner.sv
hdl/block_plotter.sv
hdl/note_highway.sv
testbench/note_highway_assertions.sv
testbench/tb_note_highway.sv

/* Bender.yml */
package:
  name: note_highway

sources:
  - files:
      - hdl/highway_pkg.sv
      - hdl/stream_stage.sv
      - hdl/beat_timer.sv
      - hdl/note_lanes.sv
      - hdl/note_scanner.sv
      - hdl/block_plotter.sv
      - hdl/note_highway.sv
  - target: test
    files:
      - testbench/note_highway_assertions.sv
      - testbench/tb_note_highway.sv
